// ==== files.f ====
+incdir+include
src/rv_pkg.sv
src/rv_issue_queue.sv
src/rv_decoder.sv
src/rv_regfile.sv
src/rv_alu.sv
src/rv_execute.sv
src/rv_core_top.sv
dv/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/rv_pkg.sv
      - src/rv_issue_queue.sv
      - src/rv_decoder.sv
      - src/rv_regfile.sv
      - src/rv_alu.sv
      - src/rv_execute.sv
      - src/rv_core_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/tb_rv_core.sv

// ==== dv/tb_rv_core.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module tb_rv_core;

  logic                clk;
  logic                reset;
  logic                instr_valid;
  logic [`RV_XLEN-1:0] instr_word;
  logic                instr_credit;
  logic                res_credit;
  logic                res_valid;
  logic [`RV_XLEN-1:0] res_pc;
  logic [`RV_XLEN-1:0] res_data;
  logic [`RV_XLEN-1:0] res_next_pc;
  logic [4:0]          res_rd;
  logic                res_illegal;

  integer seed;
  int     errors;
  int     cycles;
  int     num_sent;
  int     res_seen;
  int     credits;
  int     pending;
  logic   hold_credit;
  logic   running;
  string  test_name;

  logic [`RV_XLEN-1:0] shadow [`RV_NREGS];
  logic [`RV_XLEN-1:0] ref_pc;
  logic [`RV_XLEN-1:0] send_q [$];
  logic [`RV_XLEN-1:0] exp_pc [$];
  logic [`RV_XLEN-1:0] exp_data [$];
  logic [`RV_XLEN-1:0] exp_next [$];
  logic [4:0]          exp_rd [$];
  logic                exp_ill [$];
  logic                exp_chk [$];

  // Taken and not-taken operand pairs for each branch condition with x10 = -5 and x11 = x12 = 3
  logic [2:0] br_f3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  logic [4:0] tk_a [6]  = '{5'd11, 5'd10, 5'd10, 5'd11, 5'd11, 5'd10};
  logic [4:0] tk_b [6]  = '{5'd12, 5'd11, 5'd11, 5'd10, 5'd10, 5'd11};
  logic [4:0] nt_a [6]  = '{5'd10, 5'd11, 5'd11, 5'd10, 5'd10, 5'd11};
  logic [4:0] nt_b [6]  = '{5'd11, 5'd12, 5'd10, 5'd11, 5'd11, 5'd10};

  rv_core_top u_rv_core_top (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr_word   (instr_word),
    .instr_credit (instr_credit),
    .res_credit   (res_credit),
    .res_valid    (res_valid),
    .res_pc       (res_pc),
    .res_data     (res_data),
    .res_next_pc  (res_next_pc),
    .res_rd       (res_rd),
    .res_illegal  (res_illegal)
  );

  always #5 clk = ~clk;

  function automatic logic [`RV_XLEN-1:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3,
                                                 input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv_pkg::OP_ALU};
  endfunction

  function automatic logic [`RV_XLEN-1:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd,
                                                 input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [`RV_XLEN-1:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                                 input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OP_STORE};
  endfunction

  function automatic logic [`RV_XLEN-1:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
  endfunction

  function automatic logic [`RV_XLEN-1:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                                 input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [`RV_XLEN-1:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
  endfunction

  function automatic rv_pkg::format_e fmt_of(input logic [6:0] opc);
    case (opc)
      rv_pkg::OP_ALU:                                    return rv_pkg::FMT_R;
      rv_pkg::OP_ALUI, rv_pkg::OP_LOAD, rv_pkg::OP_JALR: return rv_pkg::FMT_I;
      rv_pkg::OP_STORE:                                  return rv_pkg::FMT_S;
      rv_pkg::OP_BRANCH:                                 return rv_pkg::FMT_B;
      rv_pkg::OP_LUI, rv_pkg::OP_AUIPC:                  return rv_pkg::FMT_U;
      rv_pkg::OP_JAL:                                    return rv_pkg::FMT_J;
      default:                                           return rv_pkg::FMT_NONE;
    endcase
  endfunction

  function automatic logic [`RV_XLEN-1:0] imm_for(input rv_pkg::format_e fmt,
                                                  input logic [`RV_XLEN-1:0] w);
    case (fmt)
      rv_pkg::FMT_I: return {{20{w[31]}}, w[31:20]};
      rv_pkg::FMT_S: return {{20{w[31]}}, w[31:25], w[11:7]};
      rv_pkg::FMT_B: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      rv_pkg::FMT_U: return {w[31:12], 12'h000};
      rv_pkg::FMT_J: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      default:       return '0;
    endcase
  endfunction

  function automatic logic [`RV_XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                  input logic reg_form,
                                                  input logic [`RV_XLEN-1:0] a,
                                                  input logic [`RV_XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      3'd0: return (reg_form && alt) ? a - b : a + b;
      3'd1: return a << sh;
      3'd2: return `RV_XLEN'($signed(a) < $signed(b));
      3'd3: return `RV_XLEN'(a < b);
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) return $signed(a) >>> sh;
        return a >> sh;
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic branch_taken(input logic [2:0] f3, input logic [`RV_XLEN-1:0] a,
                                        input logic [`RV_XLEN-1:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      3'd7:    return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // Works out the result record of one word in program order and queues the word
  task automatic issue(input logic [`RV_XLEN-1:0] w);
    rv_pkg::format_e     fmt;
    logic [6:0]          opc;
    logic [`RV_XLEN-1:0] imm;
    logic [`RV_XLEN-1:0] a;
    logic [`RV_XLEN-1:0] b;
    logic [`RV_XLEN-1:0] data;
    logic [`RV_XLEN-1:0] npc;
    logic [4:0]          rd;
    logic                chk;
    opc  = w[6:0];
    fmt  = fmt_of(opc);
    imm  = imm_for(fmt, w);
    a    = shadow[w[19:15]];
    b    = shadow[w[24:20]];
    rd   = 5'd0;
    data = '0;
    chk  = 1'b1;
    npc  = ref_pc + 4;
    case (opc)
      rv_pkg::OP_LUI:   data = imm;
      rv_pkg::OP_AUIPC: data = ref_pc + imm;
      rv_pkg::OP_JAL: begin
        data = ref_pc + 4;
        npc  = ref_pc + imm;
      end
      rv_pkg::OP_JALR: begin
        data   = ref_pc + 4;
        npc    = a + imm;
        npc[0] = 1'b0;
      end
      rv_pkg::OP_BRANCH: begin
        chk = 1'b0;
        if (branch_taken(w[14:12], a, b)) npc = ref_pc + imm;
      end
      rv_pkg::OP_LOAD, rv_pkg::OP_STORE: data = a + imm;
      rv_pkg::OP_ALUI:  data = alu_ref(w[14:12], w[30], 1'b0, a, imm);
      rv_pkg::OP_ALU:   data = alu_ref(w[14:12], w[30], 1'b1, a, b);
      default:          chk = 1'b0;
    endcase
    if (fmt == rv_pkg::FMT_R || fmt == rv_pkg::FMT_U || fmt == rv_pkg::FMT_J ||
        opc == rv_pkg::OP_ALUI || opc == rv_pkg::OP_JALR) begin
      rd = w[11:7];
    end
    if (rd != 5'd0) shadow[rd] = data;
    exp_pc.push_back(ref_pc);
    exp_data.push_back(data);
    exp_next.push_back(npc);
    exp_rd.push_back(rd);
    exp_ill.push_back(fmt == rv_pkg::FMT_NONE);
    exp_chk.push_back(chk);
    ref_pc = npc;
    send_q.push_back(w);
  endtask

  task automatic check_data(input string what, input logic [`RV_XLEN-1:0] exp,
                            input logic [`RV_XLEN-1:0] act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_reg(input string what, input logic [4:0] exp, input logic [4:0] act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s: expected %0d actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic compare_result;
    logic [`RV_XLEN-1:0] d;
    logic                chk;
    res_seen++;
    if (exp_pc.size() == 0) begin
      errors++;
      $display("%s: result for pc %h arrived with nothing expected", test_name, res_pc);
    end else begin
      d   = exp_data.pop_front();
      chk = exp_chk.pop_front();
      check_data("res_pc", exp_pc.pop_front(), res_pc);
      check_reg("res_rd", exp_rd.pop_front(), res_rd);
      check_data("res_next_pc", exp_next.pop_front(), res_next_pc);
      check_flag("res_illegal", exp_ill.pop_front(), res_illegal);
      if (chk) check_data("res_data", d, res_data);
    end
  endtask

  // The fetch model, result consumer and run limit all step on the falling edge
  always @(negedge clk) begin
    cycles++;
    if (cycles > 20 * num_sent + 200) begin
      $display("run stopped at cycle %0d with %0d results outstanding, %0d errors so far",
               cycles, exp_pc.size(), errors);
      $display("*** FAILED ***");
      $finish;
    end
    if (instr_credit === 1'b1) credits++;
    if (res_valid === 1'b1) compare_result();
    res_credit = 1'b0;
    if (!hold_credit && pending > 0) begin
      res_credit = 1'b1;
      pending--;
    end
    if (res_valid === 1'b1) pending++;
    instr_valid = 1'b0;
    if (running && credits > 0 && send_q.size() > 0) begin
      instr_word  = send_q.pop_front();
      instr_valid = 1'b1;
      credits--;
      num_sent++;
    end
  end

  task automatic wait_results;
    int limit;
    int waited;
    limit  = 20 * exp_pc.size() + 50;
    waited = 0;
    while (exp_pc.size() > 0 && waited < limit) begin
      @(negedge clk);
      waited++;
    end
    if (exp_pc.size() > 0) begin
      errors++;
      $display("%s: %0d expected results never arrived", test_name, exp_pc.size());
      exp_pc.delete();
      exp_data.delete();
      exp_next.delete();
      exp_rd.delete();
      exp_ill.delete();
      exp_chk.delete();
    end
  endtask

  task automatic test_alu;
    logic [11:0] imm;
    logic [2:0]  f3;
    test_name = "test_alu";
    for (int r = 1; r <= 8; r++) begin
      issue(u_type(20'($random(seed)), 5'(r), rv_pkg::OP_LUI));
      issue(i_type(12'($random(seed)), 5'(r), 3'd0, 5'(r), rv_pkg::OP_ALUI));
    end
    // Eight funct3 codes followed by SUB and SRA
    for (int k = 0; k < 10; k++) begin
      f3 = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
      issue(r_type((k >= 8) ? 7'h20 : 7'h00, 5'(1 + ($random(seed) & 7)),
                   5'(1 + ($random(seed) & 7)), f3, 5'(9 + k)));
    end
    for (int k = 0; k < 9; k++) begin
      f3  = (k < 8) ? 3'(k) : 3'd5;
      imm = 12'($random(seed));
      if (f3 == 3'd1 || f3 == 3'd5) imm = {(k == 8) ? 7'h20 : 7'h00, imm[4:0]};
      issue(i_type(imm, 5'(1 + ($random(seed) & 7)), f3, 5'(19 + k), rv_pkg::OP_ALUI));
    end
    issue(r_type(7'h00, 5'd10, 5'd9, 3'd0, 5'd28));
    issue(r_type(7'h20, 5'd1, 5'd28, 3'd0, 5'd29));
    issue(r_type(7'h20, 5'd2, 5'd29, 3'd5, 5'd30));
    issue(i_type(12'hFFF, 5'd30, 3'd0, 5'd28, rv_pkg::OP_ALUI));
    wait_results();
  endtask

  task automatic test_upper_jump;
    test_name = "test_upper_jump";
    issue(u_type(20'($random(seed)), 5'd5, rv_pkg::OP_AUIPC));
    issue(j_type(21'h000040, 5'd6));
    issue(j_type(21'h1FFFE8, 5'd7));
    issue(i_type(12'h101, 5'd0, 3'd0, 5'd9, rv_pkg::OP_ALUI));
    issue(i_type(12'h010, 5'd9, 3'd0, 5'd8, rv_pkg::OP_JALR));
    issue(i_type(12'h7FD, 5'd8, 3'd0, 5'd8, rv_pkg::OP_JALR));
    issue(i_type(12'($random(seed)), 5'd1, 3'd0, 5'd0, rv_pkg::OP_JALR));
    issue(u_type(20'($random(seed)), 5'd5, rv_pkg::OP_AUIPC));
    wait_results();
  endtask

  task automatic test_branch;
    test_name = "test_branch";
    issue(i_type(12'hFFB, 5'd0, 3'd0, 5'd10, rv_pkg::OP_ALUI));
    issue(i_type(12'h003, 5'd0, 3'd0, 5'd11, rv_pkg::OP_ALUI));
    issue(i_type(12'h003, 5'd0, 3'd0, 5'd12, rv_pkg::OP_ALUI));
    for (int k = 0; k < 6; k++) begin
      issue(b_type(13'h0010, tk_b[k], tk_a[k], br_f3[k]));
      issue(b_type(13'h1FF8, nt_b[k], nt_a[k], br_f3[k]));
      issue(b_type(13'h0020, 5'(1 + ($random(seed) & 7)), 5'(1 + ($random(seed) & 7)),
                   br_f3[k]));
    end
    wait_results();
  endtask

  task automatic test_x0_illegal;
    test_name = "test_x0_illegal";
    issue(i_type(12'h07B, 5'd0, 3'd0, 5'd0, rv_pkg::OP_ALUI));
    issue(u_type(20'hABCDE, 5'd0, rv_pkg::OP_LUI));
    issue(r_type(7'h00, 5'd0, 5'd0, 3'd0, 5'd13));
    issue(i_type(12'($random(seed)), 5'd0, 3'd0, 5'd31, rv_pkg::OP_ALUI));
    issue(32'hFFFF_FFFF);
    issue({25'($random(seed)), 7'b1110011});
    issue({25'($random(seed)), 7'b0001111});
    issue(r_type(7'h00, 5'd0, 5'd31, 3'd0, 5'd14));
    wait_results();
  endtask

  task automatic test_load_store;
    test_name = "test_load_store";
    for (int k = 0; k < 3; k++) begin
      issue(i_type(12'($random(seed)), 5'(1 + k), 3'b010, 5'd15, rv_pkg::OP_LOAD));
      issue(s_type(12'($random(seed)), 5'(4 + k), 5'(2 + k)));
    end
    issue(r_type(7'h00, 5'd0, 5'd15, 3'd0, 5'd16));
    wait_results();
  endtask

  task automatic test_credit;
    int total;
    int start;
    int waited;
    test_name = "test_credit";
    total     = `RV_RES_CREDITS + `RV_IQ_DEPTH + 2;
    start     = res_seen;
    // The consumer first returns the credits it still owes for the last results
    while (pending > 0) begin
      @(negedge clk);
    end
    hold_credit = 1'b1;
    for (int k = 0; k < total; k++) begin
      issue(i_type(12'($random(seed)), 5'd17, 3'd0, 5'd17, rv_pkg::OP_ALUI));
    end
    waited = 0;
    while (!(credits == 0 && send_q.size() == 2) && waited < 20 * total) begin
      @(negedge clk);
      waited++;
    end
    if (credits != 0 || send_q.size() != 2) begin
      errors++;
      $display("%s: sender did not stall with zero credits while results were held",
               test_name);
    end
    // Nothing more may retire while the consumer keeps its credits
    repeat (20) @(negedge clk);
    check_data("results while held", `RV_RES_CREDITS, `RV_XLEN'(res_seen - start));
    check_data("sender credits", '0, `RV_XLEN'(credits));
    check_data("words still unsent", 2, `RV_XLEN'(send_q.size()));
    hold_credit = 1'b0;
    wait_results();
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr_word  = '0;
    res_credit  = 1'b0;
    seed        = 45;
    errors      = 0;
    cycles      = 0;
    num_sent    = 0;
    res_seen    = 0;
    credits     = `RV_IQ_DEPTH;
    pending     = 0;
    hold_credit = 1'b0;
    running     = 1'b0;
    test_name   = "reset";
    ref_pc      = `RV_RESET_PC;
    for (int i = 0; i < `RV_NREGS; i++) begin
      shadow[i] = '0;
    end
    repeat (4) @(negedge clk);
    reset   = 1'b0;
    running = 1'b1;
    test_alu();
    test_upper_jump();
    test_branch();
    test_x0_illegal();
    test_load_store();
    test_credit();
    $display("%0d errors in %0d checked results", errors, res_seen);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== src/rv_core_top.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_core_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                instr_valid,
  input  logic [`RV_XLEN-1:0] instr_word,
  output logic                instr_credit,
  input  logic                res_credit,
  output logic                res_valid,
  output logic [`RV_XLEN-1:0] res_pc,
  output logic [`RV_XLEN-1:0] res_data,
  output logic [`RV_XLEN-1:0] res_next_pc,
  output logic [4:0]          res_rd,
  output logic                res_illegal
);

  logic                iq_valid;
  logic [`RV_XLEN-1:0] iq_word;
  logic                iq_pop;
  rv_pkg::opcode_e     opcode;
  logic [4:0]          rd;
  logic [4:0]          rs1;
  logic [4:0]          rs2;
  logic [`RV_XLEN-1:0] imm;
  logic [2:0]          f3;
  rv_pkg::alu_op_e     alu_op;
  logic                use_imm;
  logic                writes_rd;
  logic                illegal;
  logic [`RV_XLEN-1:0] rs1_data;
  logic [`RV_XLEN-1:0] rs2_data;
  logic                wr_en;
  logic [4:0]          wr_addr;
  logic [`RV_XLEN-1:0] wr_data;

  rv_issue_queue u_rv_issue_queue (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr_word   (instr_word),
    .iq_pop       (iq_pop),
    .iq_valid     (iq_valid),
    .iq_word      (iq_word),
    .instr_credit (instr_credit)
  );

  // The decoder works on the queue head directly
  rv_decoder u_rv_decoder (
    .ir        (iq_word),
    .opcode    (opcode),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm       (imm),
    .f3        (f3),
    .alu_op    (alu_op),
    .use_imm   (use_imm),
    .writes_rd (writes_rd),
    .illegal   (illegal)
  );

  rv_regfile u_rv_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  rv_execute u_rv_execute (
    .clk         (clk),
    .reset       (reset),
    .iq_valid    (iq_valid),
    .iq_pop      (iq_pop),
    .opcode      (opcode),
    .rd          (rd),
    .imm         (imm),
    .f3          (f3),
    .alu_op      (alu_op),
    .use_imm     (use_imm),
    .writes_rd   (writes_rd),
    .illegal     (illegal),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .res_credit  (res_credit),
    .res_valid   (res_valid),
    .res_pc      (res_pc),
    .res_rd      (res_rd),
    .res_data    (res_data),
    .res_next_pc (res_next_pc),
    .res_illegal (res_illegal)
  );

endmodule

// ==== src/rv_execute.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_execute (
  input  logic                clk,
  input  logic                reset,
  input  logic                iq_valid,
  output logic                iq_pop,
  input  rv_pkg::opcode_e     opcode,
  input  logic [4:0]          rd,
  input  logic [`RV_XLEN-1:0] imm,
  input  logic [2:0]          f3,
  input  rv_pkg::alu_op_e     alu_op,
  input  logic                use_imm,
  input  logic                writes_rd,
  input  logic                illegal,
  input  logic [`RV_XLEN-1:0] rs1_data,
  input  logic [`RV_XLEN-1:0] rs2_data,
  output logic                wr_en,
  output logic [4:0]          wr_addr,
  output logic [`RV_XLEN-1:0] wr_data,
  input  logic                res_credit,
  output logic                res_valid,
  output logic [`RV_XLEN-1:0] res_pc,
  output logic [4:0]          res_rd,
  output logic [`RV_XLEN-1:0] res_data,
  output logic [`RV_XLEN-1:0] res_next_pc,
  output logic                res_illegal
);

  localparam int cnt_w = $clog2(`RV_RES_CREDITS + 1);

  logic [`RV_XLEN-1:0] pc;
  logic [cnt_w-1:0]    res_cnt;
  logic                fire;
  logic [`RV_XLEN-1:0] alu_a;
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_y;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] pc_plus_imm;
  logic                taken;
  logic [`RV_XLEN-1:0] next_pc;
  logic [`RV_XLEN-1:0] result;

  // Retire only when the consumer still has room for a result
  assign fire   = iq_valid && (res_cnt != '0);
  assign iq_pop = fire;

  always_comb begin
    if (opcode == rv_pkg::OP_LUI) begin
      alu_a = '0;
    end else if (opcode == rv_pkg::OP_AUIPC) begin
      alu_a = pc;
    end else begin
      alu_a = rs1_data;
    end
  end

  assign alu_b = use_imm ? imm : rs2_data;

  rv_alu u_rv_alu (
    .a  (alu_a),
    .b  (alu_b),
    .op (alu_op),
    .y  (alu_y)
  );

  always_comb begin
    case (f3)
      3'b000:  taken = (rs1_data == rs2_data);
      3'b001:  taken = (rs1_data != rs2_data);
      3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
      3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110:  taken = (rs1_data < rs2_data);
      3'b111:  taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4    = pc + `RV_XLEN'(4);
  assign pc_plus_imm = pc + imm;

  always_comb begin
    if (opcode == rv_pkg::OP_JAL || (opcode == rv_pkg::OP_BRANCH && taken)) begin
      next_pc = pc_plus_imm;
    end else if (opcode == rv_pkg::OP_JALR) begin
      next_pc = {alu_y[`RV_XLEN-1:1], 1'b0};
    end else begin
      next_pc = pc_plus4;
    end
  end

  assign result = (opcode == rv_pkg::OP_JAL || opcode == rv_pkg::OP_JALR) ? pc_plus4 : alu_y;

  // Write-back at the retire edge lets the next instruction see the value
  assign wr_en   = fire && writes_rd;
  assign wr_addr = rd;
  assign wr_data = result;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= `RV_RESET_PC;
      res_cnt     <= cnt_w'(`RV_RES_CREDITS);
      res_valid   <= 1'b0;
      res_illegal <= 1'b0;
    end else begin
      case ({fire, res_credit})
        2'b10:   res_cnt <= res_cnt - 1'b1;
        2'b01:   res_cnt <= res_cnt + 1'b1;
        default: res_cnt <= res_cnt;
      endcase
      res_valid <= fire;
      if (fire) begin
        pc          <= next_pc;
        res_illegal <= illegal;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      res_pc      <= pc;
      res_rd      <= writes_rd ? rd : 5'd0;
      res_data    <= result;
      res_next_pc <= next_pc;
    end
  end

endmodule

// ==== src/rv_alu.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_alu (
  input  logic [`RV_XLEN-1:0] a,
  input  logic [`RV_XLEN-1:0] b,
  input  rv_pkg::alu_op_e     op,
  output logic [`RV_XLEN-1:0] y
);

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  assign shamt       = b[4:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      rv_pkg::ALU_ADD:  y = a + b;
      rv_pkg::ALU_SUB:  y = a - b;
      rv_pkg::ALU_SLL:  y = a << shamt;
      rv_pkg::ALU_SLT:  y = {{(`RV_XLEN-1){1'b0}}, lt_signed};
      rv_pkg::ALU_SLTU: y = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
      rv_pkg::ALU_XOR:  y = a ^ b;
      rv_pkg::ALU_SRL:  y = a >> shamt;
      rv_pkg::ALU_SRA:  y = $unsigned($signed(a) >>> shamt);
      rv_pkg::ALU_OR:   y = a | b;
      rv_pkg::ALU_AND:  y = a & b;
      default:          y = '0;
    endcase
  end

endmodule

// ==== src/rv_regfile.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_regfile (
  input  logic                clk,
  input  logic                reset,
  input  logic [4:0]          rs1,
  input  logic [4:0]          rs2,
  output logic [`RV_XLEN-1:0] rs1_data,
  output logic [`RV_XLEN-1:0] rs2_data,
  input  logic                wr_en,
  input  logic [4:0]          wr_addr,
  input  logic [`RV_XLEN-1:0] wr_data
);

  logic [`RV_XLEN-1:0] regs [`RV_NREGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != 5'd0) begin
      // x0 is never written so it keeps its reset value of zero
      regs[wr_addr] <= wr_data;
    end
  end

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

endmodule

// ==== src/rv_decoder.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_decoder (
  input  logic [`RV_XLEN-1:0] ir,
  output rv_pkg::opcode_e     opcode,
  output logic [4:0]          rd,
  output logic [4:0]          rs1,
  output logic [4:0]          rs2,
  output logic [`RV_XLEN-1:0] imm,
  output logic [2:0]          f3,
  output rv_pkg::alu_op_e     alu_op,
  output logic                use_imm,
  output logic                writes_rd,
  output logic                illegal
);

  rv_pkg::format_e     fmt;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic                en_rd;
  logic                en_rs1;
  logic                en_rs2;
  rv_pkg::alu_op_e     arith_op;

  assign opcode = rv_pkg::opcode_e'(ir[6:0]);
  assign f3     = ir[14:12];

  assign imm_i = {{20{ir[31]}}, ir[31:20]};
  assign imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
  assign imm_b = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
  assign imm_u = {ir[31:12], 12'b0};
  assign imm_j = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:25], ir[24:21], 1'b0};

  always_comb begin
    fmt       = rv_pkg::FMT_NONE;
    use_imm   = 1'b0;
    writes_rd = 1'b0;
    case (opcode)
      rv_pkg::OP_ALU:    begin fmt = rv_pkg::FMT_R; writes_rd = 1'b1; end
      rv_pkg::OP_ALUI:   begin fmt = rv_pkg::FMT_I; writes_rd = 1'b1; use_imm = 1'b1; end
      rv_pkg::OP_LOAD:   begin fmt = rv_pkg::FMT_I; use_imm = 1'b1; end
      rv_pkg::OP_STORE:  begin fmt = rv_pkg::FMT_S; use_imm = 1'b1; end
      rv_pkg::OP_BRANCH: fmt = rv_pkg::FMT_B;
      rv_pkg::OP_JAL:    begin fmt = rv_pkg::FMT_J; writes_rd = 1'b1; end
      // JALR forms its target in the ALU as rs1 plus imm
      rv_pkg::OP_JALR:   begin fmt = rv_pkg::FMT_I; writes_rd = 1'b1; use_imm = 1'b1; end
      rv_pkg::OP_LUI:    begin fmt = rv_pkg::FMT_U; writes_rd = 1'b1; use_imm = 1'b1; end
      rv_pkg::OP_AUIPC:  begin fmt = rv_pkg::FMT_U; writes_rd = 1'b1; use_imm = 1'b1; end
      default:           fmt = rv_pkg::FMT_NONE;
    endcase
  end

  always_comb begin
    case (fmt)
      rv_pkg::FMT_I: imm = imm_i;
      rv_pkg::FMT_S: imm = imm_s;
      rv_pkg::FMT_B: imm = imm_b;
      rv_pkg::FMT_U: imm = imm_u;
      rv_pkg::FMT_J: imm = imm_j;
      default:       imm = '0;
    endcase
  end

  assign en_rd  = (fmt == rv_pkg::FMT_R) || (fmt == rv_pkg::FMT_I) ||
                  (fmt == rv_pkg::FMT_U) || (fmt == rv_pkg::FMT_J);
  assign en_rs1 = (fmt == rv_pkg::FMT_R) || (fmt == rv_pkg::FMT_I) ||
                  (fmt == rv_pkg::FMT_S) || (fmt == rv_pkg::FMT_B);
  assign en_rs2 = (fmt == rv_pkg::FMT_R) || (fmt == rv_pkg::FMT_S) ||
                  (fmt == rv_pkg::FMT_B);

  assign rd  = en_rd  ? ir[11:7]  : 5'd0;
  assign rs1 = en_rs1 ? ir[19:15] : 5'd0;
  assign rs2 = en_rs2 ? ir[24:20] : 5'd0;

  // Funct7 bit 5 picks SUB only for register operands, but SRA in both forms
  always_comb begin
    case (f3)
      3'b000:  arith_op = (opcode == rv_pkg::OP_ALU && ir[30]) ? rv_pkg::ALU_SUB
                                                               : rv_pkg::ALU_ADD;
      3'b001:  arith_op = rv_pkg::ALU_SLL;
      3'b010:  arith_op = rv_pkg::ALU_SLT;
      3'b011:  arith_op = rv_pkg::ALU_SLTU;
      3'b100:  arith_op = rv_pkg::ALU_XOR;
      3'b101:  arith_op = ir[30] ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  arith_op = rv_pkg::ALU_OR;
      default: arith_op = rv_pkg::ALU_AND;
    endcase
  end

  assign alu_op = (opcode == rv_pkg::OP_ALU || opcode == rv_pkg::OP_ALUI) ? arith_op
                                                                          : rv_pkg::ALU_ADD;

  assign illegal = (fmt == rv_pkg::FMT_NONE);

endmodule

// ==== src/rv_issue_queue.sv ====
`timescale 1ns/100ps
`include "rv_settings.svh"

module rv_issue_queue (
  input  logic                clk,
  input  logic                reset,
  input  logic                instr_valid,
  input  logic [`RV_XLEN-1:0] instr_word,
  input  logic                iq_pop,
  output logic                iq_valid,
  output logic [`RV_XLEN-1:0] iq_word,
  output logic                instr_credit
);

  localparam int ptr_w = (`RV_IQ_DEPTH > 1) ? $clog2(`RV_IQ_DEPTH) : 1;
  localparam int cnt_w = $clog2(`RV_IQ_DEPTH + 1);

  logic [`RV_XLEN-1:0] mem [`RV_IQ_DEPTH];
  logic [ptr_w-1:0]    wr_ptr;
  logic [ptr_w-1:0]    rd_ptr;
  logic [cnt_w-1:0]    count;
  logic                push;
  logic                pop;

  // The sender's credit rule keeps push away from a full queue
  assign push = instr_valid;
  assign pop  = iq_pop && iq_valid;

  assign iq_valid = (count != '0);
  assign iq_word  = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= instr_word;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      instr_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(`RV_IQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(`RV_IQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit goes back for every entry that leaves
      instr_credit <= pop;
    end
  end

endmodule

// ==== src/rv_pkg.sv ====
package rv_pkg;

  // Major opcodes of the RV32I base set that the core understands
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_ALUI   = 7'b0010011,
    OP_ALU    = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    FMT_NONE,
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J
  } format_e;

  // The decoder maps funct fields onto these, so their encoding order is free
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

endpackage

// ==== include/rv_settings.svh ====
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path and instruction word width
`define RV_XLEN 32
`define RV_NREGS 32
`define RV_IQ_DEPTH 4
`define RV_RES_CREDITS 4
`define RV_RESET_PC 32'h0000_0000

`endif
